// File: all.f
hw/mesh_pkg.sv
hw/flit_fifo.sv
hw/spike_packetizer.sv
hw/spike_depacketizer.sv
hw/route_ctrl.sv
hw/mesh_router.sv
hw/mesh_two_by_one.sv
verif/mesh_two_by_one_tb.sv

// File: Bender.yml
package:
  name: mesh_two_by_one

sources:
  - files:
      - hw/mesh_pkg.sv
      - hw/flit_fifo.sv
      - hw/spike_packetizer.sv
      - hw/spike_depacketizer.sv
      - hw/route_ctrl.sv
      - hw/mesh_router.sv
      - hw/mesh_two_by_one.sv
  - target: test
    files:
      - verif/mesh_two_by_one_tb.sv

// File: verif/mesh_two_by_one_tb.sv
// spike mesh testbench
`timescale 1ns/1ns

module mesh_two_by_one_tb;
    import mesh_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int BURSTS         = 2;

    // index is node * 4 + port with port 0 local, 1 north, 2 south and 3 edge.
    logic             clk;
    logic             arst_n;
    word_t [1:0]      local_word;
    logic  [7:0]      in_we;
    flit_t [7:0]      in_flit;
    logic  [7:0]      nb_full;
    wire   [7:0]      req;
    wire   [7:0][3:0] eg_flit;
    wire   [7:0]      full_flag;
    wire   [31:0]     egress_word1;
    wire   [31:0]     egress_word2;

    // entries are {source index, word}.
    logic [34:0]      exp_q [8][$];
    word_t            burst_words [8][BURSTS];
    word_t            hold_words [4];
    logic [31:0]      group [8];
    int               group_cnt [8];
    logic [7:0]       prev_nb_full;
    logic             stress;
    logic [31:0]      bp_rnd;
    integer           seed;
    string            out_name [8];

    mesh_two_by_one #(
        .FIFO_DEPTH (4)
    ) u_mesh_two_by_one (
        .clk                  (clk),
        .arst_n               (arst_n),
        .local_word1          (local_word[0]),
        .write_en_local1      (in_we[0]),
        .north_flit1          (in_flit[1]),
        .write_en_north1      (in_we[1]),
        .south_flit1          (in_flit[2]),
        .write_en_south1      (in_we[2]),
        .west_flit1           (in_flit[3]),
        .write_en_west1       (in_we[3]),
        .local_word_egress1   (egress_word1),
        .write_req_local1     (req[0]),
        .north_egress_flit1   (eg_flit[1]),
        .write_req_north1     (req[1]),
        .south_egress_flit1   (eg_flit[2]),
        .write_req_south1     (req[2]),
        .west_egress_flit1    (eg_flit[3]),
        .write_req_west1      (req[3]),
        .local_full1          (full_flag[0]),
        .north_full1          (full_flag[1]),
        .south_full1          (full_flag[2]),
        .west_full1           (full_flag[3]),
        .local_neuron_full1   (nb_full[0]),
        .north_neighbor_full1 (nb_full[1]),
        .south_neighbor_full1 (nb_full[2]),
        .west_neighbor_full1  (nb_full[3]),
        .local_word2          (local_word[1]),
        .write_en_local2      (in_we[4]),
        .north_flit2          (in_flit[5]),
        .write_en_north2      (in_we[5]),
        .south_flit2          (in_flit[6]),
        .write_en_south2      (in_we[6]),
        .east_flit2           (in_flit[7]),
        .write_en_east2       (in_we[7]),
        .local_word_egress2   (egress_word2),
        .write_req_local2     (req[4]),
        .north_egress_flit2   (eg_flit[5]),
        .write_req_north2     (req[5]),
        .south_egress_flit2   (eg_flit[6]),
        .write_req_south2     (req[6]),
        .east_egress_flit2    (eg_flit[7]),
        .write_req_east2      (req[7]),
        .local_full2          (full_flag[4]),
        .north_full2          (full_flag[5]),
        .south_full2          (full_flag[6]),
        .east_full2           (full_flag[7]),
        .local_neuron_full2   (nb_full[4]),
        .north_neighbor_full2 (nb_full[5]),
        .south_neighbor_full2 (nb_full[6]),
        .east_neighbor_full2  (nb_full[7])
    );

    always #5 clk = ~clk;

    // header bit 3 picks the node, bits 1:0 the exit port.
    function automatic int expected_output(input word_t w);
        return int'({w[31], w[29:28]});
    endfunction

    function automatic word_t with_header(input logic [31:0] r, input int tgt);
        return {tgt[2], r[30], tgt[1:0], r[27:0]};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int o = 0; o < 8; o++)
            n += exp_q[o].size();
        return n;
    endfunction

    task automatic report_problem(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    // a delivery must match the oldest pending packet of some source.
    task automatic match_packet(input int o, input word_t got);
        logic [7:0] seen;
        int         hit;
        seen = '0;
        hit  = -1;
        assert (exp_q[o].size() > 0)
        else
            report_problem($sformatf("unexpected packet %h on %s", got, out_name[o]));
        for (int i = 0; i < exp_q[o].size(); i++)
        begin
            if (hit < 0 && !seen[exp_q[o][i][34:32]])
            begin
                if (exp_q[o][i][31:0] == got)
                    hit = i;
                else
                    seen[exp_q[o][i][34:32]] = 1'b1;
            end
        end
        assert (hit >= 0)
        else
            report_mismatch(out_name[o], exp_q[o][0][31:0], got);
        exp_q[o].delete(hit);
    endtask

    task automatic send_packet(input int src, input word_t w);
        int cnt;
        exp_q[expected_output(w)].push_back({src[2:0], w});
        if (src % 4 == 0)
        begin
            @(posedge clk);
            cnt = 0;
            while (full_flag[src])
            begin
                cnt++;
                assert (cnt <= TIMEOUT_CYCLES)
                else
                    report_problem($sformatf("local port of source %0d stayed busy", src));
                @(posedge clk);
            end
            local_word[src / 4] <= w;
            in_we[src]          <= 1'b1;
            @(posedge clk);
            in_we[src] <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < FLITS_PER_PKT; i++)
            begin
                @(posedge clk);
                cnt = 0;
                while (full_flag[src])
                begin
                    in_we[src] <= 1'b0;
                    cnt++;
                    assert (cnt <= TIMEOUT_CYCLES)
                    else
                        report_problem($sformatf("input %0d stayed full", src));
                    @(posedge clk);
                end
                in_flit[src] <= w[31 - 4 * i -: 4];
                in_we[src]   <= 1'b1;
            end
            @(posedge clk);
            in_we[src] <= 1'b0;
        end
    endtask

    task automatic source_burst(input int src, input logic enable);
        if (enable)
        begin
            for (int n = 0; n < BURSTS; n++)
                send_packet(src, burst_words[src][n]);
        end
    endtask

    task automatic wait_drained(input string what);
        int cnt;
        cnt = 0;
        while (pending_count() != 0)
        begin
            cnt++;
            assert (cnt <= TIMEOUT_CYCLES)
            else
                report_problem($sformatf("%s timed out with %0d packets never delivered",
                                         what, pending_count()));
            @(posedge clk);
        end
    endtask

    task automatic wait_full_flag(input int idx, input string name);
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (!full_flag[idx])
        begin
            cnt++;
            assert (cnt <= TIMEOUT_CYCLES)
            else
                report_problem($sformatf("%s never rose under back-pressure", name));
            @(posedge clk);
        end
    endtask

    // random back-pressure on every sink.
    always @(posedge clk)
    begin
        if (stress)
        begin
            bp_rnd = $random(seed);
            nb_full <= bp_rnd[7:0] & bp_rnd[15:8];
        end
    end

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            for (int o = 0; o < 8; o++)
            begin
                if (o % 4 == 0)
                begin
                    if (req[o] && !nb_full[o])
                        match_packet(o, (o == 0) ? egress_word1 : egress_word2);
                end
                else if (req[o])
                begin
                    assert (!prev_nb_full[o])
                    else
                        report_problem($sformatf("strobe on %s while the neighbor was full",
                                                 out_name[o]));
                    group[o] = {group[o][27:0], eg_flit[o]};
                    group_cnt[o]++;
                    if (group_cnt[o] == FLITS_PER_PKT)
                    begin
                        match_packet(o, group[o]);
                        group_cnt[o] = 0;
                    end
                end
            end
        end
        prev_nb_full = nb_full;
    end

    initial
    begin
        int         tgt;
        logic [7:0] mask;
        int         partial;
        clk          = 1'b0;
        arst_n       = 1'b0;
        local_word   = '0;
        in_we        = '0;
        in_flit      = '0;
        nb_full      = '0;
        prev_nb_full = '0;
        stress       = 1'b0;
        seed         = 32'h269ce767;
        out_name     = '{"local_word_egress1", "north_egress_flit1", "south_egress_flit1",
                         "west_egress_flit1", "local_word_egress2", "north_egress_flit2",
                         "south_egress_flit2", "east_egress_flit2"};
        for (int o = 0; o < 8; o++)
        begin
            group[o]     = '0;
            group_cnt[o] = 0;
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (req == '0 && full_flag == '0)
        else
            report_problem("strobes or full flags were high right after reset");

        // node 0 local back to itself.
        send_packet(0, 32'h4A5B_C3D2);
        wait_drained("local loopback");

        // node 0 local out of the east edge of node 1.
        send_packet(0, 32'hB123_4567);
        wait_drained("east edge delivery");

        // west edge flits to node 1 local.
        send_packet(3, 32'h8FED_CBA9);
        wait_drained("west to local delivery");

        // east sink of node 1 holds back the whole path.
        for (int k = 0; k < 4; k++)
            hold_words[k] = with_header($random(seed), 7);
        @(posedge clk);
        nb_full[7] <= 1'b1;
        fork
            begin
                for (int k = 0; k < 4; k++)
                    send_packet(3, hold_words[k]);
            end
            begin
                wait_full_flag(3, "west_full1");
                repeat (20) @(posedge clk);
                nb_full[7] <= 1'b0;
            end
        join
        wait_drained("back-pressure release");

        // several sources aim at one output under random back-pressure.
        for (int round = 0; round < 4; round++)
        begin
            tgt  = $random(seed) & 7;
            mask = 8'($random(seed)) | (8'h03 << (2 * round));
            for (int s = 0; s < 8; s++)
            begin
                for (int n = 0; n < BURSTS; n++)
                    burst_words[s][n] = with_header($random(seed), tgt);
            end
            @(posedge clk);
            stress <= 1'b1;
            fork
                source_burst(0, mask[0]);
                source_burst(1, mask[1]);
                source_burst(2, mask[2]);
                source_burst(3, mask[3]);
                source_burst(4, mask[4]);
                source_burst(5, mask[5]);
                source_burst(6, mask[6]);
                source_burst(7, mask[7]);
            join
            @(posedge clk);
            stress <= 1'b0;
            @(posedge clk);
            nb_full <= '0;
            wait_drained($sformatf("random round %0d", round));
        end

        // stray flits after the last packet leave a partial group behind.
        repeat (10) @(posedge clk);
        partial = 0;
        for (int o = 0; o < 8; o++)
            partial += group_cnt[o];
        assert (pending_count() == 0 && partial == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
            report_problem("packets or partial flit groups are left over at the end");
    end

endmodule

// File: hw/mesh_two_by_one.sv
// two by one spike mesh
`timescale 1ns/1ns

module mesh_two_by_one #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mesh_pkg::word_t local_word1,
    input  logic            write_en_local1,
    input  mesh_pkg::flit_t north_flit1,
    input  logic            write_en_north1,
    input  mesh_pkg::flit_t south_flit1,
    input  logic            write_en_south1,
    input  mesh_pkg::flit_t west_flit1,
    input  logic            write_en_west1,
    output mesh_pkg::word_t local_word_egress1,
    output logic            write_req_local1,
    output mesh_pkg::flit_t north_egress_flit1,
    output logic            write_req_north1,
    output mesh_pkg::flit_t south_egress_flit1,
    output logic            write_req_south1,
    output mesh_pkg::flit_t west_egress_flit1,
    output logic            write_req_west1,
    output logic            local_full1,
    output logic            north_full1,
    output logic            south_full1,
    output logic            west_full1,
    input  logic            local_neuron_full1,
    input  logic            north_neighbor_full1,
    input  logic            south_neighbor_full1,
    input  logic            west_neighbor_full1,
    input  mesh_pkg::word_t local_word2,
    input  logic            write_en_local2,
    input  mesh_pkg::flit_t north_flit2,
    input  logic            write_en_north2,
    input  mesh_pkg::flit_t south_flit2,
    input  logic            write_en_south2,
    input  mesh_pkg::flit_t east_flit2,
    input  logic            write_en_east2,
    output mesh_pkg::word_t local_word_egress2,
    output logic            write_req_local2,
    output mesh_pkg::flit_t north_egress_flit2,
    output logic            write_req_north2,
    output mesh_pkg::flit_t south_egress_flit2,
    output logic            write_req_south2,
    output mesh_pkg::flit_t east_egress_flit2,
    output logic            write_req_east2,
    output logic            local_full2,
    output logic            north_full2,
    output logic            south_full2,
    output logic            east_full2,
    input  logic            local_neuron_full2,
    input  logic            north_neighbor_full2,
    input  logic            south_neighbor_full2,
    input  logic            east_neighbor_full2
);
    import mesh_pkg::*;

    // internal east/west link, one lane each way.
    flit_t link_flit_01;
    logic  link_we_01;
    logic  link_full_0;
    flit_t link_flit_10;
    logic  link_we_10;
    logic  link_full_1;

    mesh_router #(
        .NODE_X     (0),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_node0 (
        .clk                 (clk),
        .arst_n              (arst_n),
        .local_word          (local_word1),
        .write_en_local      (write_en_local1),
        .local_full          (local_full1),
        .local_word_egress   (local_word_egress1),
        .write_req_local     (write_req_local1),
        .local_neuron_full   (local_neuron_full1),
        .north_flit          (north_flit1),
        .write_en_north      (write_en_north1),
        .north_full          (north_full1),
        .north_egress_flit   (north_egress_flit1),
        .write_req_north     (write_req_north1),
        .north_neighbor_full (north_neighbor_full1),
        .south_flit          (south_flit1),
        .write_en_south      (write_en_south1),
        .south_full          (south_full1),
        .south_egress_flit   (south_egress_flit1),
        .write_req_south     (write_req_south1),
        .south_neighbor_full (south_neighbor_full1),
        .edge_flit           (west_flit1),
        .write_en_edge       (write_en_west1),
        .edge_full           (west_full1),
        .edge_egress_flit    (west_egress_flit1),
        .write_req_edge      (write_req_west1),
        .edge_neighbor_full  (west_neighbor_full1),
        .link_flit           (link_flit_10),
        .write_en_link       (link_we_10),
        .link_full           (link_full_0),
        .link_egress_flit    (link_flit_01),
        .write_req_link      (link_we_01),
        .link_neighbor_full  (link_full_1)
    );

    mesh_router #(
        .NODE_X     (1),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_node1 (
        .clk                 (clk),
        .arst_n              (arst_n),
        .local_word          (local_word2),
        .write_en_local      (write_en_local2),
        .local_full          (local_full2),
        .local_word_egress   (local_word_egress2),
        .write_req_local     (write_req_local2),
        .local_neuron_full   (local_neuron_full2),
        .north_flit          (north_flit2),
        .write_en_north      (write_en_north2),
        .north_full          (north_full2),
        .north_egress_flit   (north_egress_flit2),
        .write_req_north     (write_req_north2),
        .north_neighbor_full (north_neighbor_full2),
        .south_flit          (south_flit2),
        .write_en_south      (write_en_south2),
        .south_full          (south_full2),
        .south_egress_flit   (south_egress_flit2),
        .write_req_south     (write_req_south2),
        .south_neighbor_full (south_neighbor_full2),
        .edge_flit           (east_flit2),
        .write_en_edge       (write_en_east2),
        .edge_full           (east_full2),
        .edge_egress_flit    (east_egress_flit2),
        .write_req_edge      (write_req_east2),
        .edge_neighbor_full  (east_neighbor_full2),
        .link_flit           (link_flit_01),
        .write_en_link       (link_we_01),
        .link_full           (link_full_1),
        .link_egress_flit    (link_flit_10),
        .write_req_link      (link_we_10),
        .link_neighbor_full  (link_full_0)
    );

endmodule

// File: hw/mesh_router.sv
// mesh router node
`timescale 1ns/1ns

module mesh_router #(
    parameter int NODE_X     = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mesh_pkg::word_t local_word,
    input  logic            write_en_local,
    output logic            local_full,
    output mesh_pkg::word_t local_word_egress,
    output logic            write_req_local,
    input  logic            local_neuron_full,
    input  mesh_pkg::flit_t north_flit,
    input  logic            write_en_north,
    output logic            north_full,
    output mesh_pkg::flit_t north_egress_flit,
    output logic            write_req_north,
    input  logic            north_neighbor_full,
    input  mesh_pkg::flit_t south_flit,
    input  logic            write_en_south,
    output logic            south_full,
    output mesh_pkg::flit_t south_egress_flit,
    output logic            write_req_south,
    input  logic            south_neighbor_full,
    input  mesh_pkg::flit_t edge_flit,
    input  logic            write_en_edge,
    output logic            edge_full,
    output mesh_pkg::flit_t edge_egress_flit,
    output logic            write_req_edge,
    input  logic            edge_neighbor_full,
    input  mesh_pkg::flit_t link_flit,
    input  logic            write_en_link,
    output logic            link_full,
    output mesh_pkg::flit_t link_egress_flit,
    output logic            write_req_link,
    input  logic            link_neighbor_full
);
    import mesh_pkg::*;

    flit_t [NUM_PORTS-1:0]     head_flit;
    logic  [NUM_PORTS-1:0]     head_valid;
    logic  [NUM_PORTS-1:0]     pop;
    logic  [NUM_PORTS-1:0]     out_blocked;
    logic  [NUM_PORTS-1:0]     out_fire;
    port_idx_t [NUM_PORTS-1:0] grant_src;
    flit_t [NUM_PORTS-1:0]     xbar_flit;
    logic                      local_stall;

    flit_t [P_LINK:P_NORTH]    in_flit;
    logic  [P_LINK:P_NORTH]    in_we;
    logic  [P_LINK:P_NORTH]    in_full;
    logic  [P_LINK:P_NORTH]    nb_full;
    flit_t                     egress_flit [P_NORTH:P_LINK];
    logic                      write_req   [P_NORTH:P_LINK];

    assign in_flit = {link_flit, edge_flit, south_flit, north_flit};
    assign in_we   = {write_en_link, write_en_edge, write_en_south, write_en_north};
    assign nb_full = {link_neighbor_full, edge_neighbor_full, south_neighbor_full,
                      north_neighbor_full};

    assign out_blocked = {nb_full, local_stall};

    spike_packetizer u_packetizer (
        .clk        (clk),
        .arst_n     (arst_n),
        .word       (local_word),
        .write_en   (write_en_local),
        .busy       (local_full),
        .head_flit  (head_flit[P_LOCAL]),
        .head_valid (head_valid[P_LOCAL]),
        .pop        (pop[P_LOCAL])
    );

    for (genvar p = P_NORTH; p <= P_LINK; p++)
    begin : g_net
        flit_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk        (clk),
            .arst_n     (arst_n),
            .flit       (in_flit[p]),
            .write_en   (in_we[p]),
            .full       (in_full[p]),
            .head_flit  (head_flit[p]),
            .head_valid (head_valid[p]),
            .pop        (pop[p])
        );

        // output stage; the strobe lasts one cycle per flit.
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
                write_req[p] <= 1'b0;
            else
                write_req[p] <= out_fire[p];
        end

        always_ff @(posedge clk)
        begin
            if (out_fire[p])
                egress_flit[p] <= xbar_flit[p];
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++)
    begin : g_xbar
        assign xbar_flit[o] = head_flit[grant_src[o]];
    end

    route_ctrl #(
        .NODE_X (NODE_X)
    ) u_route_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head_flit   (head_flit),
        .out_blocked (out_blocked),
        .grant_src   (grant_src),
        .out_fire    (out_fire),
        .pop         (pop)
    );

    spike_depacketizer u_depacketizer (
        .clk        (clk),
        .arst_n     (arst_n),
        .flit       (xbar_flit[P_LOCAL]),
        .flit_valid (out_fire[P_LOCAL]),
        .stall      (local_stall),
        .word       (local_word_egress),
        .word_valid (write_req_local),
        .sink_full  (local_neuron_full)
    );

    assign north_full        = in_full[P_NORTH];
    assign south_full        = in_full[P_SOUTH];
    assign edge_full         = in_full[P_EDGE];
    assign link_full         = in_full[P_LINK];
    assign north_egress_flit = egress_flit[P_NORTH];
    assign south_egress_flit = egress_flit[P_SOUTH];
    assign edge_egress_flit  = egress_flit[P_EDGE];
    assign link_egress_flit  = egress_flit[P_LINK];
    assign write_req_north   = write_req[P_NORTH];
    assign write_req_south   = write_req[P_SOUTH];
    assign write_req_edge    = write_req[P_EDGE];
    assign write_req_link    = write_req[P_LINK];

endmodule

// File: hw/route_ctrl.sv
// node routing control
`timescale 1ns/1ns

module route_ctrl #(
    parameter int NODE_X = 0
) (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic [mesh_pkg::NUM_PORTS-1:0]                head_valid,
    input  mesh_pkg::flit_t [mesh_pkg::NUM_PORTS-1:0]     head_flit,
    input  logic [mesh_pkg::NUM_PORTS-1:0]                out_blocked,
    output mesh_pkg::port_idx_t [mesh_pkg::NUM_PORTS-1:0] grant_src,
    output logic [mesh_pkg::NUM_PORTS-1:0]                out_fire,
    output logic [mesh_pkg::NUM_PORTS-1:0]                pop
);
    import mesh_pkg::*;

    typedef enum logic {OUT_IDLE, OUT_LOCKED} out_state_e;

    out_state_e           out_state [NUM_PORTS];
    port_idx_t            owner     [NUM_PORTS];
    port_idx_t            rr_last   [NUM_PORTS];
    logic [CNT_W-1:0]     src_cnt   [NUM_PORTS];
    port_idx_t            dest      [NUM_PORTS];
    logic [NUM_PORTS-1:0] hdr_ready;

    // dimension order: cross the link first, then take the exit port.
    always_comb
    begin
        for (int s = 0; s < NUM_PORTS; s++)
        begin
            hdr_ready[s] = head_valid[s] && (src_cnt[s] == '0);
            if (head_flit[s][3] != NODE_X[0])
                dest[s] = P_LINK;
            else
                dest[s] = port_idx_t'(head_flit[s][1:0]);
        end
    end

    always_comb
    begin
        port_idx_t cand;
        logic      found;
        cand      = '0;
        found     = 1'b0;
        grant_src = '0;
        out_fire  = '0;
        pop       = '0;
        for (int o = 0; o < NUM_PORTS; o++)
        begin
            found = 1'b0;
            if (out_state[o] == OUT_LOCKED)
            begin
                grant_src[o] = owner[o];
                out_fire[o]  = head_valid[owner[o]] && !out_blocked[o];
            end
            else
            begin
                // search starts just past the last winner.
                for (int i = 1; i <= NUM_PORTS; i++)
                begin
                    cand = port_idx_t'((int'(rr_last[o]) + i) % NUM_PORTS);
                    if (!found && hdr_ready[cand] && dest[cand] == port_idx_t'(o))
                    begin
                        found        = 1'b1;
                        grant_src[o] = cand;
                    end
                end
                out_fire[o] = found && !out_blocked[o];
            end
            if (out_fire[o])
                pop[grant_src[o]] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int o = 0; o < NUM_PORTS; o++)
            begin
                out_state[o] <= OUT_IDLE;
                owner[o]     <= '0;
                rr_last[o]   <= '0;
                src_cnt[o]   <= '0;
            end
        end
        else
        begin
            for (int s = 0; s < NUM_PORTS; s++)
            begin
                if (pop[s])
                    src_cnt[s] <= (src_cnt[s] == LAST_FLIT) ? '0 : src_cnt[s] + 1'b1;
            end
            for (int o = 0; o < NUM_PORTS; o++)
            begin
                if (out_fire[o])
                begin
                    if (out_state[o] == OUT_IDLE)
                    begin
                        out_state[o] <= OUT_LOCKED;
                        owner[o]     <= grant_src[o];
                        rr_last[o]   <= grant_src[o];
                    end
                    else if (src_cnt[owner[o]] == LAST_FLIT)
                    begin
                        out_state[o] <= OUT_IDLE;
                    end
                end
            end
        end
    end

endmodule

// File: hw/spike_depacketizer.sv
// spike word depacketizer
`timescale 1ns/1ns

module spike_depacketizer (
    input  logic            clk,
    input  logic            arst_n,
    input  mesh_pkg::flit_t flit,
    input  logic            flit_valid,
    output logic            stall,
    output mesh_pkg::word_t word,
    output logic            word_valid,
    input  logic            sink_full
);
    import mesh_pkg::*;

    logic [CNT_W-1:0] flit_cnt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            flit_cnt   <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            if (flit_valid)
                flit_cnt <= (flit_cnt == LAST_FLIT) ? '0 : flit_cnt + 1'b1;
            if (flit_valid && flit_cnt == LAST_FLIT)
                word_valid <= 1'b1;
            else if (word_valid && !sink_full)
                word_valid <= 1'b0;
        end
    end

    // first flit ends up in the top nibble.
    always_ff @(posedge clk)
    begin
        if (flit_valid)
            word <= {word[$bits(word_t)-$bits(flit_t)-1:0], flit};
    end

    // no new flits while a finished word waits for the neuron.
    assign stall = word_valid;

endmodule

// File: hw/spike_packetizer.sv
// spike word packetizer
`timescale 1ns/1ns

module spike_packetizer (
    input  logic            clk,
    input  logic            arst_n,
    input  mesh_pkg::word_t word,
    input  logic            write_en,
    output logic            busy,
    output mesh_pkg::flit_t head_flit,
    output logic            head_valid,
    input  logic            pop
);
    import mesh_pkg::*;

    typedef enum logic {PK_IDLE, PK_SEND} pk_state_e;

    pk_state_e        state;
    logic [CNT_W-1:0] flit_cnt;
    word_t            shift_word;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= PK_IDLE;
            flit_cnt <= '0;
        end
        else if (state == PK_IDLE)
        begin
            if (write_en)
            begin
                state    <= PK_SEND;
                flit_cnt <= '0;
            end
        end
        else if (pop)
        begin
            flit_cnt <= flit_cnt + 1'b1;
            if (flit_cnt == LAST_FLIT)
                state <= PK_IDLE;
        end
    end

    // top nibble is always the next flit out.
    always_ff @(posedge clk)
    begin
        if (state == PK_IDLE && write_en)
            shift_word <= word;
        else if (pop)
            shift_word <= shift_word << $bits(flit_t);
    end

    assign busy       = (state == PK_SEND);
    assign head_valid = busy;
    assign head_flit  = shift_word[$bits(word_t)-1 -: $bits(flit_t)];

endmodule

// File: hw/flit_fifo.sv
// input flit buffer
`timescale 1ns/1ns

module flit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mesh_pkg::flit_t flit,
    input  logic            write_en,
    output logic            full,
    output mesh_pkg::flit_t head_flit,
    output logic            head_valid,
    input  logic            pop
);
    import mesh_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    flit_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic             do_write;
    logic             do_read;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_write = write_en && (level != LVL_W'(FIFO_DEPTH));
    assign do_read  = pop && head_valid;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_read)
                rd_ptr <= next_ptr(rd_ptr);
            level <= level + LVL_W'(do_write) - LVL_W'(do_read);
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= flit;
    end

    assign head_flit  = mem[rd_ptr];
    assign head_valid = (level != '0);
    // one slot stays free for the flit already in flight.
    assign full       = (level >= LVL_W'(FIFO_DEPTH - 1));

endmodule

// File: hw/mesh_pkg.sv
// mesh shared definitions
package mesh_pkg;

    // one flit on any link.
    typedef logic [3:0] flit_t;

    // spike word at the neuron interface.
    typedef logic [31:0] word_t;

    // router port index.
    typedef logic [2:0] port_idx_t;

    localparam int FLITS_PER_PKT = 8;
    localparam int NUM_PORTS     = 5;
    localparam int CNT_W         = $clog2(FLITS_PER_PKT);

    localparam logic [CNT_W-1:0] LAST_FLIT = CNT_W'(FLITS_PER_PKT - 1);

    // exit ports 0 to 3 match bits 1:0 of a header flit.
    localparam port_idx_t P_LOCAL = 3'd0;
    localparam port_idx_t P_NORTH = 3'd1;
    localparam port_idx_t P_SOUTH = 3'd2;
    localparam port_idx_t P_EDGE  = 3'd3;
    localparam port_idx_t P_LINK  = 3'd4;

endpackage
